// File: fix_stimulus.txt
# T <name> <back|rand> starts a test; W <word hex> is an input word, lane 3 first in time
# E <tag> <len> <value hex> or E ERR is due 3 cycles after the W line above it
T single_word back
W 383d4601
E 8 1 46
W 313d4101
E 1 1 41
T lane_spans rand
W 33353d44
W 0134393d
E 35 1 44
W 41424301
E 49 3 414243
W 35363d58
W 59013334
E 56 2 5859
W 3d373801
E 34 2 3738
W 393d3230
W 31320131
E 9 4 32303132
W 313d6f6b
W 01313030
E 11 2 6f6b
W 303d5a01
E 1000 1 5a
T long_value rand
W 35383d41
W 42434445
W 46474849
W 4a4b4c01
E 58 12 45464748494a4b4c
T back_to_back back
W 35353d31
W 0136303d
E 55 1 31
W 3201333d
E 60 1 32
W 3401373d
E 3 1 34
W 41424301
E 7 3 414243
T double_soh rand
W 34353d41
W 42014301
E ERR
W 5a013434
W 3d414201
E 44 2 4142
T bad_tag rand
W 413d4201
E ERR
W 373d3901
E 7 1 39

// File: src.f
fix_pkg.sv
fix_delim_detect.sv
fix_field_split.sv
fix_field_assemble.sv
fix_parser_top.sv
tb_fix_parser.sv

// File: Bender.yml
package:
  name: fix_parser

sources:
  - fix_pkg.sv
  - fix_delim_detect.sv
  - fix_field_split.sv
  - fix_field_assemble.sv
  - fix_parser_top.sv
  - target: test
    files:
      - tb_fix_parser.sv

// File: tb_fix_parser.sv
/* reads fix_stimulus.txt from the project root; VALUE_BYTES is fixed at 8 here.
   each expected record is due 3 cycles after the word listed above it */
`timescale 1ns/100ps
`default_nettype none

module tb_fix_parser
	import fix_pkg::*;
();

	localparam int unsigned VALUE_BYTES = 8;
	localparam int MAX_WORDS    = 256;
	localparam int MAX_RECS     = 128;
	localparam int MAX_TESTS    = 16;
	localparam int RESET_CYCLES = 10;

	logic                     clk;
	logic                     rst;
	logic [31:0]              word;
	logic                     word_valid;
	field_t                   field;
	logic [VALUE_BYTES*8-1:0] value;
	logic                     field_valid;
	logic                     frame_err;

	logic [31:0] words [MAX_WORDS];
	int          word_test [MAX_WORDS];
	string       test_names [MAX_TESTS];
	bit          test_rand [MAX_TESTS];
	int          rec_word [MAX_RECS];
	bit          rec_err [MAX_RECS];
	logic [13:0] rec_tag [MAX_RECS];
	logic [7:0]  rec_len [MAX_RECS];
	logic [63:0] rec_val [MAX_RECS];
	int          n_words;
	int          n_recs;
	int          n_tests;
	int          rec_ptr;
	int          due_q [$];
	int          idx_q [$];
	int          cycle;
	int          limit;
	logic [31:0] lfsr_q;

	fix_parser_top #(
		.VALUE_BYTES(VALUE_BYTES)
	) DUT (
		.clk_i        (clk),
		.rst_i        (rst),
		.word_i       (word),
		.word_valid_i (word_valid),
		.field_o      (field),
		.value_o      (value),
		.field_valid_o(field_valid),
		.frame_err_o  (frame_err)
	);

	always #5 clk = ~clk;

	task automatic stop_on_error();
		$display("RESULT: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic expect_eq(input string test, input string what, input logic [63:0] exp,
		input logic [63:0] act);
		assert (exp == act) else begin
			$display("mismatch %s %s: expected %0d (0x%0h) actual %0d (0x%0h)",
				test, what, exp, exp, act, act);
			stop_on_error();
		end
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_gap(output int gap);
		logic [1:0] bits;
		for (int i = 0; i < 2; i++) begin
			lfsr_q  = lfsr_next(lfsr_q);
			bits[i] = lfsr_q[0];
		end
		gap = bits;
	endtask

	task automatic read_stimulus();
		int             fd;
		int             rc;
		int             tag_v;
		int             len_v;
		string          tok;
		string          name;
		string          mode;
		logic [1023:0]  skip_line;
		logic [63:0]    val_v;
		logic [31:0]    w;
		fd = $fopen("fix_stimulus.txt", "r");
		assert (fd != 0) else begin
			$display("could not open the stimulus file fix_stimulus.txt");
			stop_on_error();
		end
		while ($fscanf(fd, "%s", tok) == 1) begin
			if (tok == "#") begin
				rc = $fgets(skip_line, fd);
			end else if (tok == "T") begin
				rc = $fscanf(fd, "%s %s", name, mode);
				test_names[n_tests] = name;
				test_rand[n_tests]  = mode == "rand";
				n_tests++;
			end else if (tok == "W") begin
				rc = $fscanf(fd, "%h", w);
				words[n_words]     = w;
				word_test[n_words] = n_tests - 1;
				n_words++;
			end else if (tok == "E") begin
				rc = $fscanf(fd, "%s", tok);
				rec_word[n_recs] = n_words - 1;
				rec_err[n_recs]  = tok == "ERR";
				rec_tag[n_recs]  = '0;
				rec_len[n_recs]  = '0;
				rec_val[n_recs]  = '0;
				if (tok != "ERR") begin
					rc = $sscanf(tok, "%d", tag_v);
					rc = $fscanf(fd, "%d %h", len_v, val_v);
					rec_tag[n_recs] = tag_v[13:0];
					rec_len[n_recs] = len_v[7:0];
					rec_val[n_recs] = val_v;
				end
				n_recs++;
			end else begin
				$display("unknown line type %s in the stimulus file", tok);
				stop_on_error();
			end
		end
		$fclose(fd);
	endtask

	// one word for one cycle, its records fall due 3 cycles on
	task automatic drive_word(input int i);
		word       = words[i];
		word_valid = 1'b1;
		while (rec_ptr < n_recs && rec_word[rec_ptr] == i) begin
			idx_q.push_back(rec_ptr);
			due_q.push_back(cycle + 3);
			rec_ptr++;
		end
		@(negedge clk);
		word       = '0;
		word_valid = 1'b0;
	endtask

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= limit) begin
			$display("timeout at cycle %0d, the run did not finish", cycle);
			$display("RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	always @(negedge clk) begin : monitor
		int    k;
		string name;
		if (!rst) begin
			if (idx_q.size() > 0) begin
				assert (due_q[0] >= cycle) else begin
					$display("no output at cycle %0d for test %s, a record was missed",
						cycle, test_names[word_test[rec_word[idx_q[0]]]]);
					stop_on_error();
				end
			end
			if (field_valid || frame_err) begin
				assert (idx_q.size() > 0) else begin
					$display("output at cycle %0d with no record pending", cycle);
					stop_on_error();
				end
				k    = idx_q.pop_front();
				name = test_names[word_test[rec_word[k]]];
				expect_eq(name, "cycle", due_q.pop_front(), cycle);
				if (rec_err[k]) begin
					expect_eq(name, "frame_err", 1, frame_err);
					expect_eq(name, "field_valid", 0, field_valid);
				end else begin
					expect_eq(name, "field_valid", 1, field_valid);
					expect_eq(name, "frame_err", 0, frame_err);
					expect_eq(name, "tag_num", rec_tag[k], field.tag_num);
					expect_eq(name, "value_len", rec_len[k], field.value_len);
					expect_eq(name, "value", rec_val[k], value);
				end
			end
		end
	end

	initial begin
		int gap;
		clk        = 1'b0;
		rst        = 1'b1;
		word       = '0;
		word_valid = 1'b0;
		cycle      = 0;
		n_words    = 0;
		n_recs     = 0;
		n_tests    = 0;
		rec_ptr    = 0;
		lfsr_q     = 32'h1dce_8f69;
		read_stimulus();
		// at most 3 idle cycles per word
		limit = RESET_CYCLES + 4 * n_words + 20;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < n_words; i++) begin
			if (test_rand[word_test[i]]) begin
				draw_gap(gap);
				repeat (gap) @(negedge clk);
			end
			drive_word(i);
		end
		repeat (4) @(negedge clk);
		if (idx_q.size() == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			$display("%0d expected records never appeared", idx_q.size());
			stop_on_error();
		end
	end

endmodule

`default_nettype wire

// File: fix_parser_top.sv
/* no back-pressure, one word per cycle; a field shows 3 cycles after its closing SOH word */
`timescale 1ns/100ps
`default_nettype none

module fix_parser_top
	import fix_pkg::*;
#(
	parameter int unsigned VALUE_BYTES = 8
) (
	input  logic                     clk_i,
	input  logic                     rst_i,
	input  logic [31:0]              word_i,
	input  logic                     word_valid_i,
	output field_t                   field_o,
	output logic [VALUE_BYTES*8-1:0] value_o,
	output logic                     field_valid_o,
	output logic                     frame_err_o
);

	delim_t delim;
	frag_t  frag;

	fix_delim_detect u_detect (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.word_i      (word_i),
		.word_valid_i(word_valid_i),
		.delim_o     (delim)
	);

	fix_field_split u_split (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.delim_i(delim),
		.frag_o (frag)
	);

	fix_field_assemble #(
		.VALUE_BYTES(VALUE_BYTES)
	) u_assemble (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.frag_i       (frag),
		.field_o      (field_o),
		.value_o      (value_o),
		.field_valid_o(field_valid_o),
		.frame_err_o  (frame_err_o)
	);

endmodule

`default_nettype wire

// File: fix_field_assemble.sv
/* a bad tag byte in the field that a SOH opens also drops the field that it closes */
`timescale 1ns/100ps
`default_nettype none

module fix_field_assemble
	import fix_pkg::*;
#(
	parameter int unsigned VALUE_BYTES = 8
) (
	input  logic                     clk_i,
	input  logic                     rst_i,
	input  frag_t                    frag_i,
	output field_t                   field_o,
	output logic [VALUE_BYTES*8-1:0] value_o,
	output logic                     field_valid_o,
	output logic                     frame_err_o
);

	localparam int unsigned VW = VALUE_BYTES * 8;

	logic [13:0]   tag_q;
	logic [13:0]   cur_tag;
	logic [13:0]   nxt_tag;
	logic [7:0]    len_q;
	logic [7:0]    cur_len;
	logic [7:0]    nxt_len;
	logic [VW-1:0] val_q;
	logic [VW-1:0] cur_val;
	logic [VW-1:0] nxt_val;
	logic          skip_q;
	logic          skip_d;
	logic          body_first;
	logic          closing;
	logic          bad_cur;
	logic          bad_nxt;
	logic          err_now;
	logic          emit;
	field_t        field_q;
	logic [VW-1:0] value_q;
	logic          field_valid_q;
	logic          frame_err_q;

	// times ten plus digit while skipping zero padding
	function automatic logic [14:0] fold_tag(input logic [13:0] acc, input logic [31:0] bytes);
		logic [13:0] t;
		logic        bad;
		logic [7:0]  b;
		t   = acc;
		bad = 1'b0;
		for (int i = 3; i >= 0; i--) begin
			b = bytes[8*i +: 8];
			if (b >= "0" && b <= "9")
				t = 14'(t * 14'd10) + 14'(b - "0");
			else if (b != 8'h00)
				bad = 1'b1;
		end
		return {bad, t};
	endfunction

	assign closing    = frag_i.body_valid & frag_i.body_end;
	// SOH came first so the tag bytes belong to the next field
	assign body_first = closing & ~frag_i.tag_end;

	always_comb begin
		cur_tag = tag_q;
		cur_len = len_q;
		cur_val = val_q;
		bad_cur = 1'b0;
		bad_nxt = 1'b0;
		if (frag_i.tag_valid && !body_first)
			{bad_cur, cur_tag} = fold_tag(cur_tag, frag_i.tag);
		if (frag_i.body_valid) begin
			for (int i = 3; i >= 0; i--) begin
				if (frag_i.body[8*i +: 8] != 8'h00) begin
					cur_val = (cur_val << 8) | VW'(frag_i.body[8*i +: 8]);
					if (cur_len != 8'hff)
						cur_len = cur_len + 8'd1;
				end
			end
		end
		nxt_tag = closing ? 14'd0 : cur_tag;
		nxt_len = closing ? 8'd0 : cur_len;
		nxt_val = closing ? '0 : cur_val;
		if (frag_i.tag_valid && body_first)
			{bad_nxt, nxt_tag} = fold_tag(14'd0, frag_i.tag);

		err_now = frag_i.err | (bad_cur & ~skip_q) | bad_nxt;
		emit    = closing & ~skip_q & ~err_now;

		if (frag_i.err)
			skip_d = 1'b0;
		else if (closing)
			skip_d = bad_nxt;
		else
			skip_d = skip_q | bad_cur;

		// a discarded field starts over from zero
		if (frag_i.err || skip_d) begin
			nxt_tag = 14'd0;
			nxt_len = 8'd0;
			nxt_val = '0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			tag_q         <= 14'd0;
			len_q         <= 8'd0;
			val_q         <= '0;
			skip_q        <= 1'b0;
			field_valid_q <= 1'b0;
			frame_err_q   <= 1'b0;
		end else begin
			tag_q         <= nxt_tag;
			len_q         <= nxt_len;
			val_q         <= nxt_val;
			skip_q        <= skip_d;
			field_valid_q <= emit;
			frame_err_q   <= err_now;
		end
	end

	always_ff @(posedge clk_i) begin
		if (emit) begin
			field_q <= '{tag_num: cur_tag, value_len: cur_len};
			value_q <= cur_val;
		end
	end

	assign field_o       = field_q;
	assign value_o       = value_q;
	assign field_valid_o = field_valid_q;
	assign frame_err_o   = frame_err_q;

	// value bytes are never NUL so only an empty value leaves value_o all zero
	assert property (@(posedge clk_i) disable iff (rst_i)
		field_valid_o |-> (field_o.value_len == 8'd0) == (value_o == '0));

endmodule

`default_nettype wire

// File: fix_field_split.sv
/* with both delimiters in one word the later one must sit in lane 0, else err.
   after err everything is dropped up to the next SOH. */
`timescale 1ns/100ps
`default_nettype none

module fix_field_split
	import fix_pkg::*;
(
	input  logic   clk_i,
	input  logic   rst_i,
	input  delim_t delim_i,
	output frag_t  frag_o
);

	typedef enum logic [1:0] {
		WAIT_SOH = 2'd0,
		IN_TAG   = 2'd1,
		IN_VAL   = 2'd2
	} open_t;

	open_t       open_q;
	open_t       open_d;
	frag_t       frag_d;
	logic        has_soh;
	logic        has_sep;
	logic        bad;
	logic [31:0] tag_q;
	logic [31:0] body_q;
	logic        tag_valid_q;
	logic        tag_end_q;
	logic        body_valid_q;
	logic        body_end_q;
	logic        err_q;

	// bytes in lanes above pos, right-aligned
	function automatic logic [31:0] lanes_above(input logic [31:0] data, input lane_pos_t pos);
		logic [5:0] sh;
		sh = {1'b0, pos[1:0], 3'b000} + 6'd8;
		return data >> sh;
	endfunction

	// bytes in lanes below pos
	function automatic logic [31:0] lanes_below(input logic [31:0] data, input lane_pos_t pos);
		logic [31:0] mask;
		mask = ~(32'hffff_ffff << {pos[1:0], 3'b000});
		return data & mask;
	endfunction

	assign has_soh = delim_i.soh_pos != POS_NONE;
	assign has_sep = delim_i.sep_pos != POS_NONE;

	always_comb begin
		frag_d = '0;
		open_d = open_q;
		bad    = 1'b0;
		if (delim_i.valid && !delim_i.err) begin
			if (has_soh && has_sep && delim_i.soh_pos > delim_i.sep_pos) begin
				// value closes, a whole tag follows, '=' in lane 0
				bad = open_q == IN_TAG || delim_i.sep_pos != 3'd0;
				frag_d.body       = lanes_above(delim_i.data, delim_i.soh_pos);
				frag_d.body_valid = open_q == IN_VAL;
				frag_d.body_end   = open_q == IN_VAL;
				frag_d.tag        = lanes_above(lanes_below(delim_i.data, delim_i.soh_pos),
					delim_i.sep_pos);
				frag_d.tag_valid  = 1'b1;
				open_d = IN_VAL;
			end else if (has_soh && has_sep) begin
				// whole value between '=' and SOH in lane 0
				bad = open_q == IN_VAL || delim_i.soh_pos != 3'd0;
				if (open_q == IN_TAG) begin
					frag_d.tag        = lanes_above(delim_i.data, delim_i.sep_pos);
					frag_d.tag_valid  = 1'b1;
					frag_d.tag_end    = 1'b1;
					frag_d.body       = lanes_above(lanes_below(delim_i.data, delim_i.sep_pos),
						delim_i.soh_pos);
					frag_d.body_valid = 1'b1;
					frag_d.body_end   = 1'b1;
				end
				open_d = IN_TAG;
			end else if (has_soh) begin
				bad = open_q == IN_TAG;
				frag_d.body       = lanes_above(delim_i.data, delim_i.soh_pos);
				frag_d.body_valid = open_q == IN_VAL;
				frag_d.body_end   = open_q == IN_VAL;
				frag_d.tag        = lanes_below(delim_i.data, delim_i.soh_pos);
				frag_d.tag_valid  = delim_i.soh_pos != 3'd0;
				open_d = IN_TAG;
			end else if (has_sep) begin
				bad = open_q == IN_VAL;
				if (open_q == IN_TAG) begin
					frag_d.tag        = lanes_above(delim_i.data, delim_i.sep_pos);
					frag_d.tag_valid  = 1'b1;
					frag_d.tag_end    = 1'b1;
					frag_d.body       = lanes_below(delim_i.data, delim_i.sep_pos);
					frag_d.body_valid = delim_i.sep_pos != 3'd0;
					open_d = IN_VAL;
				end
			end else if (open_q == IN_TAG) begin
				frag_d.tag       = delim_i.data;
				frag_d.tag_valid = 1'b1;
			end else if (open_q == IN_VAL) begin
				frag_d.body       = delim_i.data;
				frag_d.body_valid = 1'b1;
			end
		end
		if (bad || (delim_i.valid && delim_i.err)) begin
			frag_d     = '0;
			frag_d.err = 1'b1;
			open_d     = WAIT_SOH;
		end
	end

	// a stream starts with a tag
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			open_q       <= IN_TAG;
			tag_valid_q  <= 1'b0;
			tag_end_q    <= 1'b0;
			body_valid_q <= 1'b0;
			body_end_q   <= 1'b0;
			err_q        <= 1'b0;
		end else begin
			open_q       <= open_d;
			tag_valid_q  <= frag_d.tag_valid;
			tag_end_q    <= frag_d.tag_end;
			body_valid_q <= frag_d.body_valid;
			body_end_q   <= frag_d.body_end;
			err_q        <= frag_d.err;
		end
	end

	always_ff @(posedge clk_i) begin
		tag_q  <= frag_d.tag;
		body_q <= frag_d.body;
	end

	assign frag_o = '{tag: tag_q, tag_valid: tag_valid_q, tag_end: tag_end_q, body: body_q,
		body_valid: body_valid_q, body_end: body_end_q, err: err_q};

	assert property (@(posedge clk_i) disable iff (rst_i)
		frag_o.tag_end |-> $past(delim_i.valid && delim_i.sep_pos != POS_NONE));

	assert property (@(posedge clk_i) disable iff (rst_i)
		frag_o.body_end |-> $past(delim_i.valid && delim_i.soh_pos != POS_NONE));

endmodule

`default_nettype wire

// File: fix_delim_detect.sv
/* a word with two SOH or two '=' is marked err; lanes are still reported */
`timescale 1ns/100ps
`default_nettype none

module fix_delim_detect
	import fix_pkg::*;
(
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic [31:0] word_i,
	input  logic        word_valid_i,
	output delim_t      delim_o
);

	logic [3:0]  soh_hit;
	logic [3:0]  sep_hit;
	logic        dup;
	logic [31:0] data_q;
	lane_pos_t   soh_q;
	lane_pos_t   sep_q;
	logic        valid_q;
	logic        err_q;

	function automatic lane_pos_t encode_lane(input logic [3:0] hit);
		lane_pos_t pos;
		pos = POS_NONE;
		for (int i = 0; i < 4; i++) begin
			if (hit[i])
				pos = lane_pos_t'(i);
		end
		return pos;
	endfunction

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			soh_hit[i] = word_i[8*i +: 8] == SOH_CHAR;
			sep_hit[i] = word_i[8*i +: 8] == SEP_CHAR;
		end
	end

	// more than one bit set in either hit vector
	assign dup = (|(soh_hit & (soh_hit - 4'd1))) | (|(sep_hit & (sep_hit - 4'd1)));

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			valid_q <= 1'b0;
			err_q   <= 1'b0;
		end else begin
			valid_q <= word_valid_i;
			err_q   <= word_valid_i & dup;
		end
	end

	always_ff @(posedge clk_i) begin
		data_q <= word_i;
		soh_q  <= encode_lane(soh_hit);
		sep_q  <= encode_lane(sep_hit);
	end

	assign delim_o = '{data: data_q, soh_pos: soh_q, sep_pos: sep_q, valid: valid_q, err: err_q};

	// a reported lane holds the byte it names so SOH and '=' never share one
	assert property (@(posedge clk_i) disable iff (rst_i)
		delim_o.valid && delim_o.soh_pos != POS_NONE |->
			delim_o.data[8*delim_o.soh_pos[1:0] +: 8] == SOH_CHAR);

	assert property (@(posedge clk_i) disable iff (rst_i)
		delim_o.valid && delim_o.sep_pos != POS_NONE |->
			delim_o.data[8*delim_o.sep_pos[1:0] +: 8] == SEP_CHAR);

endmodule

`default_nettype wire

// File: fix_pkg.sv
/* byte lane 3 (bits 31:24) is first in time; zero bytes in fragments are padding.
   tags are limited to four digits. */
`default_nettype none

package fix_pkg;

	// field terminator and tag/value separator
	localparam logic [7:0] SOH_CHAR = 8'h01;
	localparam logic [7:0] SEP_CHAR = 8'h3d;

	// lane 0..3, or no delimiter present
	typedef logic [2:0] lane_pos_t;
	localparam lane_pos_t POS_NONE = 3'd7;

	// detect -> split
	typedef struct packed {
		logic [31:0] data;
		lane_pos_t   soh_pos;
		lane_pos_t   sep_pos;
		logic        valid;
		logic        err;
	} delim_t;

	// split -> assemble, fragments right-aligned
	typedef struct packed {
		logic [31:0] tag;
		logic        tag_valid;
		logic        tag_end;
		logic [31:0] body;
		logic        body_valid;
		logic        body_end;
		logic        err;
	} frag_t;

	// value_len saturates at 255
	typedef struct packed {
		logic [13:0] tag_num;
		logic [7:0]  value_len;
	} field_t;

endpackage

`default_nettype wire
